// ==== id_config.svh ====
/*
 * Configuration macros for the decode stage: data and register index
 * widths, register count and the misaligned access increment.
 * Include this where the values are needed.
 */

`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Data path
`define ID_XLEN 32

// Register file
`define ID_REG_ADDR_W 5
`define ID_NUM_REGS 32

// Step to the next word of a split access, also the PC step
`define ID_ADDR_INCR 4

`endif

// ==== id_pkg.sv ====
/*
 * Shared types of the decode stage: vector typedefs for data words and
 * register indices, and the encodings of ALU, mux selects and FSM state.
 */

`default_nettype none

`include "id_config.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]       word_t;
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

  // Access size, same coding as the funct3 low bits reversed
  typedef logic [1:0] mem_type_t;
  localparam mem_type_t MEM_WORD = 2'b00;
  localparam mem_type_t MEM_HALF = 2'b01;
  localparam mem_type_t MEM_BYTE = 2'b10;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_FWD,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  typedef enum logic {
    RF_WD_EX,
    RF_WD_LSU
  } rf_wd_sel_e;

  // Writeback FSM
  typedef enum logic {
    IDLE,
    WAIT_MULTICYCLE
  } id_fsm_e;

endpackage

`default_nettype wire

// ==== id_decoder.sv ====
/*
 * Combinational decoder for the supported RV32I subset. Produces register
 * addresses, ALU and mux selects, LSU request fields and the immediates.
 */

`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module id_decoder import id_pkg::*; (
  input  word_t      instr_rdata_i,
  output logic       illegal_insn_o,
  output reg_addr_t  raddr_a_o,
  output reg_addr_t  raddr_b_o,
  output reg_addr_t  waddr_o,
  output logic       rf_we_o,
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o,
  output word_t      imm_i_o,
  output word_t      imm_s_o,
  output word_t      imm_b_o,
  output word_t      imm_u_o,
  output word_t      imm_j_o,
  output logic       data_req_o,
  output logic       data_we_o,
  output mem_type_t  data_type_o,
  output logic       data_sign_ext_o,
  output logic       branch_o,
  output logic       jump_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;
  logic       rf_we;
  logic       data_req;
  logic       branch;
  logic       jump;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  assign raddr_a_o = instr_rdata_i[19:15];
  assign raddr_b_o = instr_rdata_i[24:20];
  assign waddr_o   = instr_rdata_i[11:7];

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_i_o = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_o = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:25],
                    instr_rdata_i[11:7]};
  assign imm_b_o = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[7],
                    instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_o = {{(`ID_XLEN-32){instr_rdata_i[31]}}, instr_rdata_i[31:12], 12'b0};
  assign imm_j_o = {{(`ID_XLEN-20){instr_rdata_i[31]}}, instr_rdata_i[19:12],
                    instr_rdata_i[20], instr_rdata_i[30:21], 1'b0};

  // Size from funct3, meaningful only with a data request
  always_comb begin
    case (funct3[1:0])
      2'b00:   data_type_o = MEM_BYTE;
      2'b01:   data_type_o = MEM_HALF;
      default: data_type_o = MEM_WORD;
    endcase
  end

  assign data_sign_ext_o = ~funct3[2];

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    illegal        = 1'b0;
    rf_we          = 1'b0;
    data_req       = 1'b0;
    data_we_o      = 1'b0;
    branch         = 1'b0;
    jump           = 1'b0;
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;

    case (opcode)
      OPC_OP_IMM: begin
        rf_we = 1'b1;
        case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal        = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal        = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end

      OPC_OP: begin
        rf_we      = 1'b1;
        op_b_sel_o = OP_B_REG_B;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_operator_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_operator_o = ALU_SUB;
          {7'b0000000, 3'b001}: alu_operator_o = ALU_SLL;
          {7'b0000000, 3'b010}: alu_operator_o = ALU_SLT;
          {7'b0000000, 3'b011}: alu_operator_o = ALU_SLTU;
          {7'b0000000, 3'b100}: alu_operator_o = ALU_XOR;
          {7'b0000000, 3'b101}: alu_operator_o = ALU_SRL;
          {7'b0100000, 3'b101}: alu_operator_o = ALU_SRA;
          {7'b0000000, 3'b110}: alu_operator_o = ALU_OR;
          {7'b0000000, 3'b111}: alu_operator_o = ALU_AND;
          default:              illegal        = 1'b1;
        endcase
      end

      OPC_LUI, OPC_AUIPC: begin
        rf_we       = 1'b1;
        op_a_sel_o  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
      end

      OPC_LOAD: begin
        rf_we    = 1'b1;
        data_req = 1'b1;
        illegal  = (funct3[1:0] == 2'b11) | (funct3[2] & funct3[1]);
      end

      OPC_STORE: begin
        data_req    = 1'b1;
        data_we_o   = 1'b1;
        imm_b_sel_o = IMM_B_S;
        illegal     = funct3[2] | (funct3[1:0] == 2'b11);
      end

      OPC_BRANCH: begin
        branch      = 1'b1;
        op_b_sel_o  = OP_B_REG_B;
        imm_b_sel_o = IMM_B_B;
        case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal        = 1'b1;
        endcase
      end

      OPC_JAL: begin
        // Link value is PC + 4 from the ALU
        rf_we       = 1'b1;
        jump        = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_INCR_PC;
      end

      default: illegal = 1'b1;
    endcase
  end

  // An illegal encoding must have no side effects
  assign illegal_insn_o = illegal;
  assign rf_we_o        = rf_we & ~illegal;
  assign data_req_o     = data_req & ~illegal;
  assign branch_o       = branch & ~illegal;
  assign jump_o         = jump & ~illegal;

endmodule

`default_nettype wire

// ==== id_operand_mux.sv ====
/*
 * ALU operand selection. Picks the immediate and the A/B operands, and
 * forces the address step for the second half of a misaligned access.
 */

`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module id_operand_mux import id_pkg::*; (
  input  op_a_sel_e  op_a_sel_i,
  input  op_b_sel_e  op_b_sel_i,
  input  imm_b_sel_e imm_b_sel_i,
  input  word_t      imm_i_i,
  input  word_t      imm_s_i,
  input  word_t      imm_b_i,
  input  word_t      imm_u_i,
  input  word_t      imm_j_i,
  input  word_t      rdata_a_i,
  input  word_t      rdata_b_i,
  input  word_t      pc_i,
  input  logic       lsu_addr_incr_req_i,
  input  word_t      lsu_addr_last_i,
  output word_t      operand_a_o,
  output word_t      operand_b_o
);

  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  word_t      imm;

  // Second access: last LSU address plus one word
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : op_a_sel_i;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : op_b_sel_i;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  operand_a_o = rdata_a_i;
      OP_A_FWD:    operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: operand_a_o = pc_i;
      default:     operand_a_o = '0;
    endcase
  end

  always_comb begin
    case (imm_b_sel)
      IMM_B_I:       imm = imm_i_i;
      IMM_B_S:       imm = imm_s_i;
      IMM_B_B:       imm = imm_b_i;
      IMM_B_U:       imm = imm_u_i;
      IMM_B_J:       imm = imm_j_i;
      // No compressed support, so both steps are one word
      default:       imm = word_t'(`ID_ADDR_INCR);
    endcase
  end

  assign operand_b_o = (op_b_sel == OP_B_IMM) ? imm : rdata_b_i;

endmodule

`default_nettype wire

// ==== id_register_file.sv ====
/*
 * Integer register file built from flip-flops. Two asynchronous read
 * ports and one write port on the rising clock edge; x0 reads as zero.
 */

`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module id_register_file import id_pkg::*; (
  input  logic      clk_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  word_t regs [`ID_NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== id_wb_fsm.sv ====
/*
 * Writeback control for the decode stage. Tracks loads, stores, taken
 * branches and jumps until completion and decides when rd is written.
 */

`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module id_wb_fsm import id_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       instr_new_i,
  input  logic       instr_fetch_err_i,
  input  logic       data_req_i,
  input  logic       rf_we_i,
  input  logic       branch_i,
  input  logic       jump_i,
  input  logic       branch_decision_i,
  input  logic       ex_valid_i,
  input  logic       lsu_valid_i,
  input  logic       lsu_load_err_i,
  output logic       executing_o,
  output logic       rf_we_o,
  output rf_wd_sel_e rf_wd_sel_o,
  output logic       stall_o,
  output logic       instr_ret_o,
  output logic       perf_branch_o,
  output logic       perf_tbranch_o
);

  id_fsm_e state_q, state_d;
  logic    multicycle;
  logic    done_q, done_d;
  logic    we_wb;

  assign multicycle = data_req_i | branch_i | jump_i;

  // Still executing while new, or while a multicycle op is pending
  assign executing_o = (instr_new_i | (multicycle & ~done_q)) & ~instr_fetch_err_i;

  // Multicycle ops write only on completion
  assign rf_we_o     = executing_o & (multicycle ? we_wb : rf_we_i);
  assign rf_wd_sel_o = data_req_i ? RF_WD_LSU : RF_WD_EX;

  assign perf_tbranch_o = perf_branch_o & branch_decision_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    done_d        = done_q;
    we_wb         = 1'b0;
    stall_o       = 1'b0;
    instr_ret_o   = 1'b0;
    perf_branch_o = 1'b0;

    case (state_q)
      IDLE: begin
        // Detect multicycle ops only in their first cycle
        if (instr_new_i && !instr_fetch_err_i) begin
          if (branch_i) begin
            perf_branch_o = 1'b1;
            state_d       = branch_decision_i ? WAIT_MULTICYCLE : IDLE;
            stall_o       = branch_decision_i;
            done_d        = ~branch_decision_i;
            instr_ret_o   = ~branch_decision_i;
          end else if (data_req_i || jump_i) begin
            state_d = WAIT_MULTICYCLE;
            stall_o = 1'b1;
            done_d  = 1'b0;
          end else begin
            done_d      = 1'b0;
            instr_ret_o = 1'b1;
          end
        end
      end

      WAIT_MULTICYCLE: begin
        if ((data_req_i && lsu_valid_i) || (!data_req_i && ex_valid_i)) begin
          state_d     = IDLE;
          done_d      = 1'b1;
          we_wb       = rf_we_i & ~(data_req_i & lsu_load_err_i);
          instr_ret_o = 1'b1;
        end else begin
          stall_o = 1'b1;
        end
      end

      default: state_d = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
/*
 * Instruction decode stage top level. Connects decoder, operand muxes,
 * register file and writeback FSM, and drives the requests to EX and LSU.
 */

`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  logic      instr_new_i,
  input  word_t     instr_rdata_i,
  input  logic      instr_fetch_err_i,
  input  word_t     pc_id_i,
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,
  input  logic      lsu_valid_i,
  input  logic      lsu_load_err_i,
  input  logic      lsu_addr_incr_req_i,
  input  word_t     lsu_addr_last_i,
  input  word_t     regfile_wdata_ex_i,
  input  word_t     regfile_wdata_lsu_i,
  output logic      illegal_insn_o,
  output logic      id_in_ready_o,
  output alu_op_e   alu_operator_ex_o,
  output word_t     alu_operand_a_ex_o,
  output word_t     alu_operand_b_ex_o,
  output logic      data_req_ex_o,
  output logic      data_we_ex_o,
  output mem_type_t data_type_ex_o,
  output logic      data_sign_ext_ex_o,
  output word_t     data_wdata_ex_o,
  output logic      perf_branch_o,
  output logic      perf_tbranch_o,
  output logic      instr_ret_o
);

  // Decoder outputs
  logic       illegal_dec;
  reg_addr_t  raddr_a;
  reg_addr_t  raddr_b;
  reg_addr_t  waddr;
  logic       rf_we_dec;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       data_req_dec;
  logic       branch_dec;
  logic       jump_dec;

  // Register file and writeback
  word_t      rdata_a;
  word_t      rdata_b;
  word_t      rf_wdata;
  logic       rf_we;
  rf_wd_sel_e rf_wd_sel;
  logic       executing;
  logic       stall;

  id_decoder u_decoder (
    .instr_rdata_i   (instr_rdata_i),
    .illegal_insn_o  (illegal_dec),
    .raddr_a_o       (raddr_a),
    .raddr_b_o       (raddr_b),
    .waddr_o         (waddr),
    .rf_we_o         (rf_we_dec),
    .alu_operator_o  (alu_operator_ex_o),
    .op_a_sel_o      (op_a_sel),
    .op_b_sel_o      (op_b_sel),
    .imm_b_sel_o     (imm_b_sel),
    .imm_i_o         (imm_i),
    .imm_s_o         (imm_s),
    .imm_b_o         (imm_b),
    .imm_u_o         (imm_u),
    .imm_j_o         (imm_j),
    .data_req_o      (data_req_dec),
    .data_we_o       (data_we_ex_o),
    .data_type_o     (data_type_ex_o),
    .data_sign_ext_o (data_sign_ext_ex_o),
    .branch_o        (branch_dec),
    .jump_o          (jump_dec)
  );

  id_operand_mux u_operand_mux (
    .op_a_sel_i          (op_a_sel),
    .op_b_sel_i          (op_b_sel),
    .imm_b_sel_i         (imm_b_sel),
    .imm_i_i             (imm_i),
    .imm_s_i             (imm_s),
    .imm_b_i             (imm_b),
    .imm_u_i             (imm_u),
    .imm_j_i             (imm_j),
    .rdata_a_i           (rdata_a),
    .rdata_b_i           (rdata_b),
    .pc_i                (pc_id_i),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .operand_a_o         (alu_operand_a_ex_o),
    .operand_b_o         (alu_operand_b_ex_o)
  );

  assign rf_wdata = (rf_wd_sel == RF_WD_LSU) ? regfile_wdata_lsu_i : regfile_wdata_ex_i;

  id_register_file u_register_file (
    .clk_i     (clk_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_wb_fsm u_wb_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_new_i       (instr_new_i),
    .instr_fetch_err_i (instr_fetch_err_i),
    .data_req_i        (data_req_dec),
    .rf_we_i           (rf_we_dec),
    .branch_i          (branch_dec),
    .jump_i            (jump_dec),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_load_err_i    (lsu_load_err_i),
    .executing_o       (executing),
    .rf_we_o           (rf_we),
    .rf_wd_sel_o       (rf_wd_sel),
    .stall_o           (stall),
    .instr_ret_o       (instr_ret_o),
    .perf_branch_o     (perf_branch_o),
    .perf_tbranch_o    (perf_tbranch_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Outputs to EX and LSU
  //////////////////////////////////////////////////////////////////////

  assign illegal_insn_o = instr_valid_i & illegal_dec;
  assign id_in_ready_o  = ~stall;

  // Request held until the access completes
  assign data_req_ex_o   = executing & data_req_dec;
  assign data_wdata_ex_o = rdata_b;

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset source. Drives a 20 ns clock and holds the
 * active low reset for the first five rising edges.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_no <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_id_stage.sv ====
/*
 * Testbench for the decode stage. Writes every register first, then runs
 * random RV32I instructions from a fixed seed against a reference model of
 * the decode rules and the register file.
 */

`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module tb_id_stage import id_pkg::*; ();

  localparam int N_INSTR     = 2000;
  // Ten cycles per instruction is well above the longest case
  localparam int CYCLE_LIMIT = N_INSTR * 10;

  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

  logic      clk;
  logic      rst_n;
  logic      instr_valid, instr_new, instr_fetch_err, branch_decision;
  logic      ex_valid, lsu_valid, lsu_load_err, lsu_addr_incr_req;
  word_t     instr_rdata, pc_id, lsu_addr_last, wdata_ex, wdata_lsu;
  logic      illegal_insn, id_in_ready, data_req, data_we, data_sign_ext;
  logic      perf_branch, perf_tbranch, instr_ret;
  alu_op_e   alu_operator;
  word_t     operand_a, operand_b, data_wdata;
  mem_type_t data_type;

  integer    seed;
  integer    errors;
  integer    checks;
  integer    cycle_cnt;
  word_t     reg_model [`ID_NUM_REGS];

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  id_stage u_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .instr_valid_i       (instr_valid),
    .instr_new_i         (instr_new),
    .instr_rdata_i       (instr_rdata),
    .instr_fetch_err_i   (instr_fetch_err),
    .pc_id_i             (pc_id),
    .branch_decision_i   (branch_decision),
    .ex_valid_i          (ex_valid),
    .lsu_valid_i         (lsu_valid),
    .lsu_load_err_i      (lsu_load_err),
    .lsu_addr_incr_req_i (lsu_addr_incr_req),
    .lsu_addr_last_i     (lsu_addr_last),
    .regfile_wdata_ex_i  (wdata_ex),
    .regfile_wdata_lsu_i (wdata_lsu),
    .illegal_insn_o      (illegal_insn),
    .id_in_ready_o       (id_in_ready),
    .alu_operator_ex_o   (alu_operator),
    .alu_operand_a_ex_o  (operand_a),
    .alu_operand_b_ex_o  (operand_b),
    .data_req_ex_o       (data_req),
    .data_we_ex_o        (data_we),
    .data_type_ex_o      (data_type),
    .data_sign_ext_ex_o  (data_sign_ext),
    .data_wdata_ex_o     (data_wdata),
    .perf_branch_o       (perf_branch),
    .perf_tbranch_o      (perf_tbranch),
    .instr_ret_o         (instr_ret)
  );

  ////////////////////////////////////////////////////////////////////
  // Reference model of the decode rules
  ////////////////////////////////////////////////////////////////////

  function automatic logic legal_instr(input word_t ins);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = ins[14:12];
    f7 = ins[31:25];
    case (ins[6:0])
      OPC_OP_IMM: begin
        if (f3 == 3'b001) return f7 == 7'h00;
        if (f3 == 3'b101) return (f7 == 7'h00) || (f7 == 7'h20);
        return 1'b1;
      end
      OPC_OP:     return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101));
      OPC_LUI, OPC_AUIPC, OPC_JAL: return 1'b1;
      OPC_LOAD:   return (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
      OPC_STORE:  return f3 <= 3'b010;
      OPC_BRANCH: return (f3 != 3'b010) && (f3 != 3'b011);
      default:    return 1'b0;
    endcase
  endfunction

  function automatic alu_op_e expected_alu_op(input word_t ins);
    if (ins[6:0] == OPC_BRANCH) begin
      case (ins[14:12])
        3'b000:  return ALU_EQ;
        3'b001:  return ALU_NE;
        3'b100:  return ALU_LT;
        3'b101:  return ALU_GE;
        3'b110:  return ALU_LTU;
        default: return ALU_GEU;
      endcase
    end
    // Address and upper immediate forms all add
    if (ins[6:0] != OPC_OP_IMM && ins[6:0] != OPC_OP) return ALU_ADD;
    case (ins[14:12])
      3'b000:  return (ins[6:0] == OPC_OP && ins[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ins[30] ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic word_t sext_imm_i(input word_t ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic word_t sext_imm_s(input word_t ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  function automatic word_t upper_imm(input word_t ins);
    return {ins[31:12], 12'h000};
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    checks = checks + 1;
    if (exp !== act) begin
      errors = errors + 1;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Combinational outputs of a legal instruction in its first cycle
  task automatic check_decode(input word_t ins, input word_t pc);
    word_t      a;
    word_t      b;
    logic [6:0] opc;
    mem_type_t  size;
    opc = ins[6:0];
    a   = reg_model[ins[19:15]];
    b   = reg_model[ins[24:20]];
    case (opc)
      OPC_OP_IMM, OPC_LOAD: b = sext_imm_i(ins);
      OPC_STORE: b = sext_imm_s(ins);
      OPC_LUI: begin
        a = '0;
        b = upper_imm(ins);
      end
      OPC_AUIPC: begin
        a = pc;
        b = upper_imm(ins);
      end
      OPC_JAL: begin
        a = pc;
        b = word_t'(`ID_ADDR_INCR);
      end
      default: ;
    endcase
    check_value("alu_operator", word_t'(expected_alu_op(ins)), word_t'(alu_operator));
    check_value("operand_a", a, operand_a);
    check_value("operand_b", b, operand_b);
    if (opc == OPC_LOAD || opc == OPC_STORE) begin
      case (ins[13:12])
        2'b00:   size = MEM_BYTE;
        2'b01:   size = MEM_HALF;
        default: size = MEM_WORD;
      endcase
      check_value("eff_addr", reg_model[ins[19:15]] + b, operand_a + operand_b);
      check_value("data_we", word_t'(opc == OPC_STORE), word_t'(data_we));
      check_value("data_type", word_t'(size), word_t'(data_type));
    end
    if (opc == OPC_LOAD) check_value("data_sign_ext", word_t'(!ins[14]), word_t'(data_sign_ext));
    if (opc == OPC_STORE) check_value("data_wdata", reg_model[ins[24:20]], data_wdata);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  task automatic run_instr(input word_t ins, input logic fetch_err);
    logic      legal, is_load, is_mem, is_branch, is_jal, single_wr;
    logic      taken, load_err, multi, incr;
    logic [6:0] opc;
    reg_addr_t rd;
    word_t     pc, last_addr;
    integer    r, delay, i;
    opc       = ins[6:0];
    rd        = ins[11:7];
    legal     = legal_instr(ins);
    is_load   = legal && (opc == OPC_LOAD);
    is_mem    = legal && (opc == OPC_LOAD || opc == OPC_STORE);
    is_branch = legal && (opc == OPC_BRANCH);
    is_jal    = legal && (opc == OPC_JAL);
    single_wr = legal && (opc == OPC_OP_IMM || opc == OPC_OP || opc == OPC_LUI ||
                          opc == OPC_AUIPC);
    pc        = $random(seed) & 32'hffff_fffc;
    r         = $random(seed);
    taken     = r[0];
    load_err  = is_load && (r[3:2] == 2'b00);
    delay     = r[5:4];
    multi     = !fetch_err && (is_mem || is_jal || (is_branch && taken));

    @(posedge clk);
    instr_valid       <= 1'b1;
    instr_new         <= 1'b1;
    instr_rdata       <= ins;
    instr_fetch_err   <= fetch_err;
    pc_id             <= pc;
    branch_decision   <= taken;
    ex_valid          <= 1'b0;
    lsu_valid         <= 1'b0;
    lsu_load_err      <= 1'b0;
    lsu_addr_incr_req <= 1'b0;
    wdata_ex          <= $random(seed);
    wdata_lsu         <= $random(seed);
    @(negedge clk);
    check_value("illegal_insn", word_t'(!legal), word_t'(illegal_insn));
    if (legal) check_decode(ins, pc);
    check_value("perf_branch", word_t'(is_branch && !fetch_err), word_t'(perf_branch));
    check_value("perf_tbranch", word_t'(is_branch && !fetch_err && taken),
                word_t'(perf_tbranch));
    check_value("data_req", word_t'(is_mem && !fetch_err), word_t'(data_req));
    check_value("id_in_ready", word_t'(!multi), word_t'(id_in_ready));
    if (legal || fetch_err) begin
      check_value("instr_ret", word_t'(!multi && !fetch_err), word_t'(instr_ret));
    end
    if (single_wr && !fetch_err && rd != '0) reg_model[rd] = wdata_ex;

    if (multi) begin
      for (i = 0; i < delay; i = i + 1) begin
        r         = $random(seed);
        incr      = is_mem && r[0];
        last_addr = $random(seed);
        @(posedge clk);
        instr_new         <= 1'b0;
        lsu_addr_incr_req <= incr;
        lsu_addr_last     <= last_addr;
        wdata_ex          <= $random(seed);
        wdata_lsu         <= $random(seed);
        @(negedge clk);
        check_value("wait_ready", '0, word_t'(id_in_ready));
        check_value("wait_instr_ret", '0, word_t'(instr_ret));
        check_value("wait_data_req", word_t'(is_mem), word_t'(data_req));
        if (incr) begin
          check_value("misaligned_a", last_addr, operand_a);
          check_value("misaligned_b", word_t'(`ID_ADDR_INCR), operand_b);
        end
      end
      // Completion strobe from the side that owns the instruction
      @(posedge clk);
      instr_new         <= 1'b0;
      lsu_addr_incr_req <= 1'b0;
      ex_valid          <= !is_mem;
      lsu_valid         <= is_mem;
      lsu_load_err      <= load_err;
      wdata_ex          <= $random(seed);
      wdata_lsu         <= $random(seed);
      @(negedge clk);
      check_value("done_instr_ret", 32'd1, word_t'(instr_ret));
      check_value("done_ready", 32'd1, word_t'(id_in_ready));
      check_value("done_data_req", word_t'(is_mem), word_t'(data_req));
      if (is_jal && rd != '0) reg_model[rd] = wdata_ex;
      if (is_load && !load_err && rd != '0) reg_model[rd] = wdata_lsu;
    end
  endtask

  // Idle cycle with a random word on the bus and no valid instruction
  task automatic insert_bubble();
    integer r;
    r = $random(seed);
    @(posedge clk);
    instr_valid       <= 1'b0;
    instr_new         <= 1'b0;
    instr_rdata       <= r;
    instr_fetch_err   <= 1'b0;
    ex_valid          <= 1'b0;
    lsu_valid         <= 1'b0;
    lsu_load_err      <= 1'b0;
    lsu_addr_incr_req <= 1'b0;
    @(negedge clk);
    check_value("bubble_illegal", '0, word_t'(illegal_insn));
    check_value("bubble_instr_ret", '0, word_t'(instr_ret));
  endtask

  task automatic make_instr(output word_t ins);
    integer r;
    ins = $random(seed);
    r   = $random(seed);
    case ($unsigned(r) % 10)
      0:       ins[6:0] = OPC_OP_IMM;
      1, 8:    ins[6:0] = OPC_OP;
      2:       ins[6:0] = OPC_LUI;
      3:       ins[6:0] = OPC_AUIPC;
      4:       ins[6:0] = OPC_LOAD;
      5:       ins[6:0] = OPC_STORE;
      6:       ins[6:0] = OPC_BRANCH;
      7:       ins[6:0] = OPC_JAL;
      default: ;
    endcase
    // Mostly valid funct7 with a random one now and then
    if ((ins[6:0] == OPC_OP_IMM || ins[6:0] == OPC_OP) && r[6:4] != 3'b111) begin
      ins[31:25] = r[7] ? 7'h20 : 7'h00;
    end
  endtask

  initial begin
    word_t  ins;
    integer i;
    integer r;
    seed              = 32'h95f5_05e3;
    errors            = 0;
    checks            = 0;
    reg_model[0]      = '0;
    instr_valid       <= 1'b0;
    instr_new         <= 1'b0;
    instr_rdata       <= 32'h0000_0013;
    instr_fetch_err   <= 1'b0;
    pc_id             <= '0;
    branch_decision   <= 1'b0;
    ex_valid          <= 1'b0;
    lsu_valid         <= 1'b0;
    lsu_load_err      <= 1'b0;
    lsu_addr_incr_req <= 1'b0;
    lsu_addr_last     <= '0;
    wdata_ex          <= '0;
    wdata_lsu         <= '0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("reset_instr_ret", '0, word_t'(instr_ret));
    check_value("reset_perf_branch", '0, word_t'(perf_branch));
    check_value("reset_ready", 32'd1, word_t'(id_in_ready));

    // ADDI to x1 .. x31 so that every register holds a known value
    for (i = 1; i < `ID_NUM_REGS; i = i + 1) begin
      r   = $random(seed);
      ins = {r[11:0], 5'd0, 3'b000, i[4:0], OPC_OP_IMM};
      run_instr(ins, 1'b0);
    end

    for (i = 0; i < N_INSTR - (`ID_NUM_REGS - 1); i = i + 1) begin
      make_instr(ins);
      r = $random(seed);
      run_instr(ins, r[3:0] == 4'h0);
      if (r[6:4] == 3'b000) insert_bubble();
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_mux.sv
id_register_file.sv
id_wb_fsm.sv
id_stage.sv
tb_clock_gen.sv
tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
